// ==== testbench/exc_cases.txt ====
# mtc0 addr wdata hw | pc ds mem_op vaddr itlb dtlb ri sys eret ov | flush code new_pc | rd rd_val rd rd_val
# code 1f leaves the cause unchecked, rd 00 skips that read back
0 00 00000000 00 00400000 0 0 00000000 0 0 0 1 0 0 1 08 80000180 0e 00400000 0d 00000020
0 00 00000000 00 00400010 0 0 00000000 1 0 0 0 0 1 1 02 80000180 08 00400010 0e 00400010
0 00 00000000 00 00400024 1 0 00000000 0 0 0 0 0 1 1 0c 80000180 0e 00400020 0d 80000030
0 00 00000000 00 00400030 0 0 00000000 0 0 1 1 1 0 1 08 80000180 0e 00400030 0d 00000020
0 00 00000000 00 00400040 0 3 10000002 0 0 1 0 0 1 1 0a 80000180 0e 00400040 08 00400010
0 00 00000000 00 00400050 0 3 10000006 0 0 0 0 0 0 1 04 80000180 08 10000006 0e 00400050
0 00 00000000 00 00400060 0 5 10000011 0 0 0 0 0 0 1 05 80000180 08 10000011 0d 00000014
0 00 00000000 00 00400070 0 6 10000020 0 1 0 0 0 0 1 03 80000180 08 10000020 0d 0000000c
0 00 00000000 00 00400080 0 1 10000033 0 1 0 0 0 0 1 02 80000180 08 10000033 0e 00400080
0 00 00000000 00 00400090 0 0 10000044 0 1 0 0 0 0 0 00 00000000 0e 00400080 08 10000033
0 00 00000000 00 004000a0 0 3 10000040 0 0 0 0 0 0 0 00 00000000 0e 00400080 0d 00000008
0 00 00000000 00 004000b2 0 0 00000000 0 0 0 0 0 0 1 04 80000180 08 004000b2 0e 004000b2
1 0e 00400200 00 004000c0 0 0 00000000 0 0 0 0 1 0 1 1f 00400200 0c 00000000 0e 00400200
1 0c 00000010 00 80001000 0 0 00000000 0 0 0 0 0 0 1 04 80000180 08 80001000 0c 00000012
1 0c 00000010 00 00400100 0 3 80000010 0 0 0 0 0 0 1 04 80000180 08 80000010 0e 00400100
1 0c 00000001 01 00400110 0 0 00000000 0 0 0 0 0 0 0 00 00000000 0c 00000001 0d 00000410
1 0c 00000403 01 00400120 0 0 00000000 0 0 0 0 0 0 0 00 00000000 0c 00000403 0e 00400100
1 0c 00000401 01 00400130 0 0 00000000 0 0 0 0 0 1 1 00 80000180 0d 00000400 0c 00000403
1 0f 9fc00000 00 00400140 0 0 00000000 0 0 0 1 0 0 1 08 9fc00180 0f 9fc00000 0e 00400140
1 0d 00000100 00 00400150 0 0 00000000 0 0 0 0 0 0 0 00 00000000 0d 00000120 0c 00000403
1 0c 00000101 00 00400160 0 0 00000000 0 0 0 0 0 0 1 00 9fc00180 0d 00000100 0e 00400160

// ==== compile.f ====
+incdir+hw
hw/exc_pkg.sv
hw/commit_stage.sv
hw/exception.sv
hw/cp0_regs.sv
hw/exc_unit_top.sv
testbench/exc_unit_assert.sv
testbench/exc_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the exception unit testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exc_unit_tb -f compile.f \
    && ./obj_dir/Vexc_unit_tb \
    || { echo "exc_unit build or run returned an error"; exit 1; }

// ==== testbench/exc_unit_tb.sv ====
`include "exc_config.svh"

module exc_unit_tb import exc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FLUSH_WAIT = 4;
    localparam int MAX_CASES  = 64;

    logic        clk;
    logic        reset;
    logic        commit_valid;
    logic [31:0] pc;
    logic        in_delayslot;
    mem_op_t     mem_op;
    logic [31:0] mem_vaddr;
    logic        itlb_miss;
    logic        dtlb_miss;
    logic        invalid_inst;
    logic        syscall;
    logic        eret;
    logic        overflow;
    logic [5:0]  hardware_int;
    logic        mtc0_we;
    cp0_reg_t    cp0_addr;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        flush;
    exc_code_t   exp_code;
    logic [31:0] exception_new_pc;

    // fields of one case line.
    logic [31:0] f_mtc0, f_addr, f_wdata, f_hw;
    logic [31:0] f_pc, f_ds, f_memop, f_vaddr;
    logic [31:0] f_itlb, f_dtlb, f_ri, f_sys, f_eret, f_ov;
    logic [31:0] f_flush, f_code, f_newpc;
    logic [31:0] f_rd1_addr, f_rd1_val, f_rd2_addr, f_rd2_val;
    int          case_num;

    exc_unit_top UUT (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] case %0d %s: got 0x%h, expected 0x%h", case_num, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "bit mismatch on %s", name);
        end
    endtask

    task automatic check_code(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            $display("[ERROR] case %0d %s: got 0x%h, expected 0x%h", case_num, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "code mismatch on %s", name);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] case %0d %s: got 0x%h, expected 0x%h", case_num, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////
    // bus drivers
    ////////////////////////////////////////

    task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        mtc0_we   <= 1'b1;
        cp0_addr  <= cp0_reg_t'(addr);
        cp0_wdata <= data;
        @(posedge clk);
        mtc0_we <= 1'b0;
    endtask

    // combinational read, sampled mid cycle.
    task automatic read_cp0(input logic [4:0] addr, input logic [31:0] exp);
        cp0_reg_t reg_sel;
        reg_sel = cp0_reg_t'(addr);
        if (addr != 5'd0) begin
            @(posedge clk);
            cp0_addr <= reg_sel;
            @(negedge clk);
            check_word($sformatf("cp0_rdata[%s]", reg_sel.name()), cp0_rdata, exp);
        end
    endtask

    task automatic drive_commit;
        @(posedge clk);
        commit_valid <= 1'b1;
        pc           <= f_pc;
        in_delayslot <= f_ds[0];
        mem_op       <= mem_op_t'(f_memop[2:0]);
        mem_vaddr    <= f_vaddr;
        itlb_miss    <= f_itlb[0];
        dtlb_miss    <= f_dtlb[0];
        invalid_inst <= f_ri[0];
        syscall      <= f_sys[0];
        eret         <= f_eret[0];
        overflow     <= f_ov[0];
        hardware_int <= f_hw[5:0];
        @(posedge clk);
        commit_valid <= 1'b0;
        itlb_miss    <= 1'b0;
        dtlb_miss    <= 1'b0;
        invalid_inst <= 1'b0;
        syscall      <= 1'b0;
        eret         <= 1'b0;
        overflow     <= 1'b0;
    endtask

    task automatic wait_for_flush(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < FLUSH_WAIT) begin
            @(negedge clk);
            seen = flush;
            cycles++;
        end
    endtask

    task automatic run_case;
        logic seen;
        if (f_mtc0[0]) begin
            write_cp0(f_addr[4:0], f_wdata);
        end
        drive_commit();
        wait_for_flush(seen);
        if (f_flush[0]) begin
            if (!seen) begin
                $display("case %0d: flush did not arrive within %0d cycles", case_num,
                         FLUSH_WAIT);
                $display("Simulation failed");
                $fatal(1, "flush timeout");
            end else begin
                if (f_code[4:0] != 5'h1f) begin
                    check_code("exp_code", exp_code, exc_code_t'(f_code[4:0]));
                end
                check_word("exception_new_pc", exception_new_pc, f_newpc);
            end
        end else begin
            check_bit("flush", seen, 1'b0);
        end
        // single cycle pulse.
        @(posedge clk);
        @(negedge clk);
        check_bit("flush", flush, 1'b0);
        read_cp0(f_rd1_addr[4:0], f_rd1_val);
        read_cp0(f_rd2_addr[4:0], f_rd2_val);
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        clk          = 1'b0;
        reset        <= 1'b1;
        commit_valid <= 1'b0;
        pc           <= '0;
        in_delayslot <= 1'b0;
        mem_op       <= NONE;
        mem_vaddr    <= '0;
        itlb_miss    <= 1'b0;
        dtlb_miss    <= 1'b0;
        invalid_inst <= 1'b0;
        syscall      <= 1'b0;
        eret         <= 1'b0;
        overflow     <= 1'b0;
        hardware_int <= '0;
        mtc0_we      <= 1'b0;
        cp0_addr     <= STATUS;
        cp0_wdata    <= '0;
        case_num     = 0;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("flush", flush, 1'b0);
        // exl set, ie clear.
        read_cp0(STATUS, 32'h0000_0002);
        read_cp0(EBASE, {`EBASE_RESET, 12'h000});

        fd = $fopen("testbench/exc_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file testbench/exc_cases.txt");
            $display("Simulation failed");
            $fatal(1, "missing case file");
        end
        while (!$feof(fd) && case_num < MAX_CASES) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_mtc0, f_addr, f_wdata, f_hw, f_pc, f_ds, f_memop, f_vaddr,
                    f_itlb, f_dtlb, f_ri, f_sys, f_eret, f_ov, f_flush, f_code,
                    f_newpc, f_rd1_addr, f_rd1_val, f_rd2_addr, f_rd2_val);
                if (n != 21) begin
                    $display("case line after case %0d has %0d fields, not 21", case_num, n);
                    $display("Simulation failed");
                    $fatal(1, "malformed case line");
                end else begin
                    case_num++;
                    run_case();
                end
            end
        end
        $fclose(fd);

        if (case_num == 0) begin
            $display("no cases were read from the case file");
            $display("Simulation failed");
            $fatal(1, "empty case file");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== testbench/exc_unit_assert.sv ====
module exc_unit_assert import exc_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        commit_valid,
    input logic        eret,
    input logic        flush,
    input logic        cp0_wr_exp,
    input logic        cp0_clean_exl,
    input exc_code_t   exp_code,
    input logic [31:0] exception_new_pc,
    input logic [31:0] epc
);

    timeunit 1ns;
    timeprecision 1ps;

    // nothing is flushed coming out of reset.
    a_reset_quiet: assert property (@(posedge clk) reset |=> !flush)
        else $error("flush high in the cycle after reset");

    a_exc_or_eret: assert property (@(posedge clk) disable iff (reset)
        !(cp0_wr_exp && cp0_clean_exl))
        else $error("exception write and exl clear in the same cycle");

    // an eret that no exception outranks returns to epc.
    a_eret_target: assert property (@(posedge clk) disable iff (reset)
        commit_valid && eret |=> cp0_wr_exp ||
            (flush && cp0_clean_exl && exception_new_pc == epc))
        else $error("eret commit did not redirect to epc");

    a_code_legal: assert property (@(posedge clk) disable iff (reset)
        flush |-> exp_code inside {INT, TLBL, TLBS, ADEL, ADES, SYS, RI, OV})
        else $error("flush with an undefined exception code");

endmodule

bind exc_unit_top exc_unit_assert u_exc_unit_assert (
    .clk              (clk),
    .reset            (reset),
    .commit_valid     (commit_valid),
    .eret             (eret),
    .flush            (flush),
    .cp0_wr_exp       (cp0_wr_exp),
    .cp0_clean_exl    (cp0_clean_exl),
    .exp_code         (exp_code),
    .exception_new_pc (exception_new_pc),
    .epc              (epc)
);

// ==== hw/exc_unit_top.sv ====
module exc_unit_top import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        commit_valid,
    input  logic [31:0] pc,
    input  logic        in_delayslot,
    input  mem_op_t     mem_op,
    input  logic [31:0] mem_vaddr,
    input  logic        itlb_miss,
    input  logic        dtlb_miss,
    input  logic        invalid_inst,
    input  logic        syscall,
    input  logic        eret,
    input  logic        overflow,
    input  logic [5:0]  hardware_int,
    input  logic        mtc0_we,
    input  cp0_reg_t    cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    output logic        flush,
    output exc_code_t   exp_code,
    output logic [31:0] exception_new_pc
);

    // commit stage to exception.
    logic        stage_valid;
    logic [31:0] stage_pc;
    logic        stage_delayslot;
    logic [31:0] stage_vaddr;
    logic        stage_we;
    logic        iaddr_illegal;
    logic        daddr_illegal;
    logic        itlb_miss_q;
    logic        dtlb_miss_q;
    logic        syscall_q;
    logic        invalid_q;
    logic        overflow_q;
    logic        eret_q;

    // cp0 state feeding back.
    logic [7:0]  pending_int;
    logic        allow_int;
    logic [19:0] ebase;
    logic [31:0] epc;
    logic        user_mode;

    // exception record.
    logic        cp0_wr_exp;
    logic        cp0_clean_exl;
    logic [31:0] exp_epc;
    logic [31:0] exp_bad_vaddr;
    logic        exp_delayslot;

    commit_stage u_commit_stage (
        .clk             (clk),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .pc              (pc),
        .in_delayslot    (in_delayslot),
        .mem_op          (mem_op),
        .mem_vaddr       (mem_vaddr),
        .itlb_miss       (itlb_miss),
        .dtlb_miss       (dtlb_miss),
        .invalid_inst    (invalid_inst),
        .syscall         (syscall),
        .eret            (eret),
        .overflow        (overflow),
        .user_mode       (user_mode),
        .stage_valid     (stage_valid),
        .stage_pc        (stage_pc),
        .stage_delayslot (stage_delayslot),
        .stage_vaddr     (stage_vaddr),
        .stage_we        (stage_we),
        .iaddr_illegal   (iaddr_illegal),
        .daddr_illegal   (daddr_illegal),
        .itlb_miss_q     (itlb_miss_q),
        .dtlb_miss_q     (dtlb_miss_q),
        .syscall_q       (syscall_q),
        .invalid_q       (invalid_q),
        .overflow_q      (overflow_q),
        .eret_q          (eret_q)
    );

    exception u_exception (
        .stage_valid      (stage_valid),
        .stage_pc         (stage_pc),
        .stage_delayslot  (stage_delayslot),
        .stage_vaddr      (stage_vaddr),
        .stage_we         (stage_we),
        .iaddr_illegal    (iaddr_illegal),
        .daddr_illegal    (daddr_illegal),
        .itlb_miss_q      (itlb_miss_q),
        .dtlb_miss_q      (dtlb_miss_q),
        .syscall_q        (syscall_q),
        .invalid_q        (invalid_q),
        .overflow_q       (overflow_q),
        .eret_q           (eret_q),
        .pending_int      (pending_int),
        .allow_int        (allow_int),
        .ebase            (ebase),
        .epc              (epc),
        .flush            (flush),
        .cp0_wr_exp       (cp0_wr_exp),
        .cp0_clean_exl    (cp0_clean_exl),
        .exp_code         (exp_code),
        .exp_epc          (exp_epc),
        .exp_bad_vaddr    (exp_bad_vaddr),
        .exp_delayslot    (exp_delayslot),
        .exception_new_pc (exception_new_pc)
    );

    cp0_regs u_cp0_regs (
        .clk           (clk),
        .reset         (reset),
        .mtc0_we       (mtc0_we),
        .cp0_addr      (cp0_addr),
        .cp0_wdata     (cp0_wdata),
        .hardware_int  (hardware_int),
        .cp0_wr_exp    (cp0_wr_exp),
        .cp0_clean_exl (cp0_clean_exl),
        .exp_code      (exp_code),
        .exp_epc       (exp_epc),
        .exp_bad_vaddr (exp_bad_vaddr),
        .exp_delayslot (exp_delayslot),
        .cp0_rdata     (cp0_rdata),
        .pending_int   (pending_int),
        .allow_int     (allow_int),
        .ebase         (ebase),
        .epc           (epc),
        .user_mode     (user_mode)
    );

endmodule

// ==== hw/cp0_regs.sv ====
`include "exc_config.svh"

module cp0_regs import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        mtc0_we,
    input  cp0_reg_t    cp0_addr,
    input  logic [31:0] cp0_wdata,
    input  logic [5:0]  hardware_int,
    input  logic        cp0_wr_exp,
    input  logic        cp0_clean_exl,
    input  exc_code_t   exp_code,
    input  logic [31:0] exp_epc,
    input  logic [31:0] exp_bad_vaddr,
    input  logic        exp_delayslot,
    output logic [31:0] cp0_rdata,
    output logic [7:0]  pending_int,
    output logic        allow_int,
    output logic [19:0] ebase,
    output logic [31:0] epc,
    output logic        user_mode
);

    // status fields.
    logic        ie;
    logic        exl;
    logic        um;
    logic [7:0]  im;

    // cause fields.
    logic        bd;
    logic [5:0]  hw_ip;
    logic [1:0]  sw_ip;
    exc_code_t   exc_code;

    logic [31:0] badvaddr;
    logic        mtc0_ok;
    logic        addr_exc;

    // exception side wins over a software write.
    assign mtc0_ok  = mtc0_we & ~cp0_wr_exp & ~cp0_clean_exl;
    assign addr_exc = exp_code inside {TLBL, TLBS, ADEL, ADES};

    ////////////////////////////////////////
    // status, cause, ebase
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ie       <= 1'b0;
            exl      <= 1'b1;
            um       <= 1'b0;
            im       <= '0;
            bd       <= 1'b0;
            hw_ip    <= '0;
            sw_ip    <= '0;
            exc_code <= INT;
            ebase    <= `EBASE_RESET;
        end else begin
            hw_ip <= hardware_int;
            if (cp0_wr_exp) begin
                exl      <= 1'b1;
                bd       <= exp_delayslot;
                exc_code <= exp_code;
            end else if (cp0_clean_exl) begin
                exl <= 1'b0;
            end else if (mtc0_ok) begin
                case (cp0_addr)
                    STATUS: begin
                        ie  <= cp0_wdata[0];
                        exl <= cp0_wdata[1];
                        um  <= cp0_wdata[4];
                        im  <= cp0_wdata[15:8];
                    end
                    CAUSE:   sw_ip <= cp0_wdata[9:8];
                    EBASE:   ebase <= cp0_wdata[31:12];
                    default: ;
                endcase
            end
        end
    end

    // epc and badvaddr.
    always_ff @(posedge clk) begin
        if (cp0_wr_exp) begin
            epc <= exp_epc;
            if (addr_exc) begin
                badvaddr <= exp_bad_vaddr;
            end
        end else if (mtc0_ok && cp0_addr == EPC) begin
            epc <= cp0_wdata;
        end
    end

    ////////////////////////////////////////
    // read port and interrupt qualify
    ////////////////////////////////////////

    always_comb begin
        case (cp0_addr)
            BADVADDR: cp0_rdata = badvaddr;
            STATUS:   cp0_rdata = {16'h0000, im, 3'b000, um, 2'b00, exl, ie};
            CAUSE:    cp0_rdata = {bd, 15'h0000, hw_ip, sw_ip, 1'b0, exc_code, 2'b00};
            EPC:      cp0_rdata = epc;
            EBASE:    cp0_rdata = {ebase, 12'h000};
            default:  cp0_rdata = '0;
        endcase
    end

    assign pending_int = {hw_ip, sw_ip} & im;
    assign allow_int   = ie & ~exl;
    assign user_mode   = um & ~exl;

endmodule

// ==== hw/exception.sv ====
`include "exc_config.svh"

module exception import exc_pkg::*; (
    input  logic        stage_valid,
    input  logic [31:0] stage_pc,
    input  logic        stage_delayslot,
    input  logic [31:0] stage_vaddr,
    input  logic        stage_we,
    input  logic        iaddr_illegal,
    input  logic        daddr_illegal,
    input  logic        itlb_miss_q,
    input  logic        dtlb_miss_q,
    input  logic        syscall_q,
    input  logic        invalid_q,
    input  logic        overflow_q,
    input  logic        eret_q,
    input  logic [7:0]  pending_int,
    input  logic        allow_int,
    input  logic [19:0] ebase,
    input  logic [31:0] epc,
    output logic        flush,
    output logic        cp0_wr_exp,
    output logic        cp0_clean_exl,
    output exc_code_t   exp_code,
    output logic [31:0] exp_epc,
    output logic [31:0] exp_bad_vaddr,
    output logic        exp_delayslot,
    output logic [31:0] exception_new_pc
);

    logic        take_int;
    logic [31:0] vector_pc;

    assign take_int  = stage_valid & allow_int & (|pending_int);
    assign vector_pc = {ebase, 12'h000} + `EXC_VECTOR_OFFSET;

    // highest cause wins, same order as the commit pipe checks.
    always_comb begin
        flush            = 1'b1;
        cp0_wr_exp       = 1'b1;
        cp0_clean_exl    = 1'b0;
        exp_code         = INT;
        exp_epc          = stage_delayslot ? (stage_pc - 32'd4) : stage_pc;
        exp_bad_vaddr    = '0;
        exp_delayslot    = stage_delayslot;
        exception_new_pc = vector_pc;

        if (take_int) begin
            exp_code = INT;
        end else if (iaddr_illegal) begin
            exp_bad_vaddr = stage_pc;
            exp_code      = ADEL;
        end else if (itlb_miss_q) begin
            exp_bad_vaddr = stage_pc;
            exp_code      = TLBL;
        end else if (syscall_q) begin
            exp_code = SYS;
        end else if (invalid_q) begin
            exp_code = RI;
        end else if (overflow_q) begin
            exp_code = OV;
        end else if (eret_q) begin
            // pseudo exception, return to epc.
            cp0_wr_exp       = 1'b0;
            cp0_clean_exl    = 1'b1;
            exception_new_pc = epc;
        end else if (daddr_illegal) begin
            exp_bad_vaddr = stage_vaddr;
            exp_code      = stage_we ? ADES : ADEL;
        end else if (dtlb_miss_q) begin
            exp_bad_vaddr = stage_vaddr;
            exp_code      = stage_we ? TLBS : TLBL;
        end else begin
            flush      = 1'b0;
            cp0_wr_exp = 1'b0;
        end
    end

endmodule

// ==== hw/commit_stage.sv ====
`include "exc_config.svh"

module commit_stage import exc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        commit_valid,
    input  logic [31:0] pc,
    input  logic        in_delayslot,
    input  mem_op_t     mem_op,
    input  logic [31:0] mem_vaddr,
    input  logic        itlb_miss,
    input  logic        dtlb_miss,
    input  logic        invalid_inst,
    input  logic        syscall,
    input  logic        eret,
    input  logic        overflow,
    input  logic        user_mode,
    output logic        stage_valid,
    output logic [31:0] stage_pc,
    output logic        stage_delayslot,
    output logic [31:0] stage_vaddr,
    output logic        stage_we,
    output logic        iaddr_illegal,
    output logic        daddr_illegal,
    output logic        itlb_miss_q,
    output logic        dtlb_miss_q,
    output logic        syscall_q,
    output logic        invalid_q,
    output logic        overflow_q,
    output logic        eret_q
);

    logic        valid_q;
    logic [31:0] pc_q;
    logic        delayslot_q;
    mem_op_t     mem_op_q;
    logic [31:0] vaddr_q;
    logic        data_access;
    logic        data_misaligned;

    // flags are qualified on the way in.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= 1'b0;
            itlb_miss_q <= 1'b0;
            dtlb_miss_q <= 1'b0;
            syscall_q   <= 1'b0;
            invalid_q   <= 1'b0;
            overflow_q  <= 1'b0;
            eret_q      <= 1'b0;
        end else begin
            valid_q     <= commit_valid;
            itlb_miss_q <= commit_valid & itlb_miss;
            dtlb_miss_q <= commit_valid & dtlb_miss & (mem_op != NONE);
            syscall_q   <= commit_valid & syscall;
            invalid_q   <= commit_valid & invalid_inst;
            overflow_q  <= commit_valid & overflow;
            eret_q      <= commit_valid & eret;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid) begin
            pc_q        <= pc;
            delayslot_q <= in_delayslot;
            mem_op_q    <= mem_op;
            vaddr_q     <= mem_vaddr;
        end
    end

    ////////////////////////////////////////
    // address checks
    ////////////////////////////////////////

    always_comb begin
        case (mem_op_q)
            LH, SH:  data_misaligned = vaddr_q[0];
            LW, SW:  data_misaligned = |vaddr_q[1:0];
            default: data_misaligned = 1'b0;
        endcase
    end

    assign data_access = (mem_op_q != NONE);

    assign stage_valid     = valid_q;
    assign stage_pc        = valid_q ? pc_q : '0;
    assign stage_delayslot = valid_q & delayslot_q;
    assign stage_vaddr     = valid_q ? vaddr_q : '0;
    assign stage_we        = valid_q & (mem_op_q inside {SB, SH, SW});

    // kernel segment is off limits in user mode.
    assign iaddr_illegal = valid_q &
                           ((|pc_q[1:0]) | (user_mode & pc_q[`USER_LIMIT_BIT]));
    assign daddr_illegal = valid_q & data_access &
                           (data_misaligned | (user_mode & vaddr_q[`USER_LIMIT_BIT]));

endmodule

// ==== hw/exc_pkg.sv ====
package exc_pkg;

    // ExcCode field of the Cause register.
    typedef enum logic [4:0] {
        INT  = 5'd0,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    // memory access of the committing instruction.
    typedef enum logic [2:0] {
        NONE = 3'd0,
        LB   = 3'd1,
        LH   = 3'd2,
        LW   = 3'd3,
        SB   = 3'd4,
        SH   = 3'd5,
        SW   = 3'd6
    } mem_op_t;

    // CP0 register numbers, select 0 only.
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        EBASE    = 5'd15
    } cp0_reg_t;

endpackage

// ==== hw/exc_config.svh ====
`ifndef EXC_CONFIG_SVH
`define EXC_CONFIG_SVH

// general exception vector, offset from the EBase page.
`define EXC_VECTOR_OFFSET 32'h0000_0180

// EBase page after reset, kseg0 base.
`define EBASE_RESET 20'h80000

// user accesses with this bit set fall in the kernel segment.
`define USER_LIMIT_BIT 31

`endif
